//--- include/dir_cfg.svh
`ifndef DIR_CFG_SVH
`define DIR_CFG_SVH

// sets tracked per cache
`define DIR_SETS 4
// ways per set
`define DIR_ASSOC 2
// caches tracked, odd count leaves the last row of a set half used
`define DIR_NUM_LCE 3
// physical address bits
`define DIR_PADDR_W 16
// byte offset inside a block
`define DIR_BLOCK_OFF_W 3
// tag sets packed into one memory row
`define DIR_TAG_SETS_PER_ROW 2

// derived sizes, kept as literals
`define DIR_SET_W 2
// block offset plus set index
`define DIR_TAG_OFF 5
`define DIR_TAG_W 11
`define DIR_ROWS_PER_SET 2
`define DIR_ROWS 8
// row address bits
`define DIR_ROW_W 3
`define DIR_LCE_W 2
`define DIR_WAY_W 1

`endif

//--- design/dir_pkg.sv
`include "dir_cfg.svh"

package dir_pkg;

  // coherence state, anything but e_coh_i is a valid entry
  typedef enum logic [2:0] {
    e_coh_i = 3'd0,
    e_coh_s = 3'd1,
    e_coh_e = 3'd2,
    e_coh_m = 3'd3,
    e_coh_o = 3'd4,
    e_coh_f = 3'd5
  } coh_state_e;

  // directory commands
  typedef enum logic [2:0] {
    e_op_rdw = 3'd0,
    e_op_rde = 3'd1,
    e_op_wde = 3'd2,
    e_op_wds = 3'd3,
    e_op_clr = 3'd4
  } dir_op_e;

  // controller states
  typedef enum logic [2:0] {
    e_st_reset      = 3'd0,
    e_st_init       = 3'd1,
    e_st_ready      = 3'd2,
    e_st_read_full  = 3'd3,
    e_st_read_entry = 3'd4
  } dir_state_e;

  typedef struct packed {
    logic [`DIR_TAG_W-1:0] tag;
    coh_state_e            state;
  } dir_entry_s;

  // all ways of one cache in one set
  typedef dir_entry_s [`DIR_ASSOC-1:0] dir_tag_set_t;

  typedef struct packed {
    dir_tag_set_t [`DIR_TAG_SETS_PER_ROW-1:0] tag_set;
  } dir_row_s;

  typedef struct packed {
    dir_op_e                 op;
    logic [`DIR_LCE_W-1:0]   lce;
    logic [`DIR_WAY_W-1:0]   way;
    logic [`DIR_PADDR_W-1:0] addr;
    coh_state_e              state;
  } dir_cmd_s;

  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [`DIR_ROW_W-1:0] addr;
    dir_row_s              mask;
    dir_row_s              data;
  } ram_req_s;

  typedef struct packed {
    logic                  hit;
    logic [`DIR_WAY_W-1:0] way;
    coh_state_e            state;
    logic                  sel_hit;
    coh_state_e            sel_state;
    logic [`DIR_TAG_W-1:0] sel_tag;
  } tag_res_s;

  typedef struct packed {
    logic                  clear;
    logic                  capture_full;
    logic [`DIR_LCE_W-1:0] row_num;
    logic                  capture_entry;
    logic                  slot_sel;
    logic                  done;
  } collect_s;

  typedef struct packed {
    logic                                     v;
    logic [`DIR_NUM_LCE-1:0]                  hits;
    logic [`DIR_NUM_LCE-1:0][`DIR_WAY_W-1:0]  ways;
    coh_state_e [`DIR_NUM_LCE-1:0]            states;
  } dir_sharers_s;

endpackage

//--- design/dir_ram.sv
`timescale 1ns/10ps
`include "dir_cfg.svh"

module dir_ram (
  input  logic              clk_i,
  input  dir_pkg::ram_req_s req_i,
  output dir_pkg::dir_row_s row_o
);
  import dir_pkg::*;

  // one row holds every tag set of one set for two caches
  dir_row_s mem [`DIR_ROWS];

  // current row content, used as the base of a masked write
  dir_row_s cur_row;
  // row after merging write data under the mask
  dir_row_s merged_row;

  assign cur_row = mem[req_i.addr];

  // per-bit merge
  // masked bits take the new data, the rest keep the stored value
  assign merged_row = dir_row_s'((cur_row & ~req_i.mask) | (req_i.data & req_i.mask));

  // single port
  // a write and a read never happen in the same cycle
  always_ff @(posedge clk_i) begin
    if (req_i.en) begin
      if (req_i.we) begin
        mem[req_i.addr] <= merged_row;
      end else begin
        // read data is valid the cycle after the request
        row_o <= cur_row;
      end
    end
  end

  // row_o holds its last value while the port idles or writes
  // so the controller can sample it late if needed

endmodule

//--- design/dir_tag_check.sv
`timescale 1ns/10ps
`include "dir_cfg.svh"

module dir_tag_check (
  input  dir_pkg::dir_tag_set_t   entries_i,
  input  logic                    slot_v_i,
  input  logic [`DIR_TAG_W-1:0]   tag_i,
  input  logic [`DIR_WAY_W-1:0]   sel_way_i,
  output dir_pkg::tag_res_s       res_o
);
  import dir_pkg::*;

  // per-way match, gated by slot valid
  logic [`DIR_ASSOC-1:0] way_match;
  // entry picked by the request way
  dir_entry_s            sel_entry;

  always_comb begin
    for (int w = 0; w < `DIR_ASSOC; w++) begin
      way_match[w] = slot_v_i
                     && (entries_i[w].state != e_coh_i)
                     && (entries_i[w].tag == tag_i);
    end
  end

  assign sel_entry = entries_i[sel_way_i];

  always_comb begin
    // no hit reports way 0 and invalid state
    res_o = '0;
    // walk down so the lowest matching way is written last and wins
    for (int w = `DIR_ASSOC - 1; w >= 0; w--) begin
      if (way_match[w]) begin
        res_o.hit   = 1'b1;
        res_o.way   = `DIR_WAY_W'(w);
        res_o.state = entries_i[w].state;
      end
    end
    // selected way, used by entry reads
    res_o.sel_tag   = sel_entry.tag;
    res_o.sel_state = sel_entry.state;
    res_o.sel_hit   = slot_v_i
                      && (sel_entry.state != e_coh_i)
                      && (sel_entry.tag == tag_i);
  end

endmodule

//--- design/dir_ctrl.sv
`timescale 1ns/10ps
`include "dir_cfg.svh"

module dir_ctrl (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               cmd_v_i,
  input  dir_pkg::dir_cmd_s                  cmd_i,
  output logic                               busy_o,
  output dir_pkg::ram_req_s                  ram_req_o,
  output logic [`DIR_TAG_SETS_PER_ROW-1:0]   slot_v_o,
  output logic [`DIR_TAG_W-1:0]              tag_o,
  output logic [`DIR_WAY_W-1:0]              sel_way_o,
  output dir_pkg::collect_s                  collect_o
);
  import dir_pkg::*;

  dir_state_e state_r, state_n;
  // init walks all rows, full read walks rows of one set
  logic [`DIR_ROW_W-1:0] cnt_r, cnt_n;

  // request registers
  logic [`DIR_LCE_W-1:0] lce_r, lce_n;
  logic [`DIR_WAY_W-1:0] way_r, way_n;
  logic [`DIR_TAG_W-1:0] tag_r, tag_n;
  // next row address of the full read walk
  logic [`DIR_ROW_W-1:0] row_r, row_n;

  // command decode
  logic [`DIR_SET_W-1:0] set_idx;
  logic [`DIR_TAG_W-1:0] cmd_tag;
  logic [`DIR_ROW_W-1:0] entry_row;
  logic                  cmd_slot;
  logic                  last_row;

  // raw set index, no bank hashing
  assign set_idx  = cmd_i.addr[`DIR_BLOCK_OFF_W +: `DIR_SET_W];
  assign cmd_tag  = cmd_i.addr[`DIR_TAG_OFF +: `DIR_TAG_W];
  // two caches per row, so lce>>1 picks the row group
  assign entry_row = `DIR_ROW_W'((cmd_i.lce >> 1) * `DIR_SETS + set_idx);
  // low lce bit picks the tag set within the row
  assign cmd_slot = cmd_i.lce[0];
  assign last_row = (cnt_r == `DIR_ROW_W'(`DIR_ROWS_PER_SET - 1));

  assign tag_o     = tag_r;
  assign sel_way_o = way_r;

  always_comb begin
    state_n = state_r;
    cnt_n   = cnt_r;
    lce_n   = lce_r;
    way_n   = way_r;
    tag_n   = tag_r;
    row_n   = row_r;

    ram_req_o = '0;
    slot_v_o  = '0;
    collect_o = '0;
    // only ready takes commands
    busy_o    = 1'b1;

    case (state_r)
      e_st_reset: begin
        cnt_n   = '0;
        state_n = e_st_init;
      end

      e_st_init: begin
        // zero one row per cycle
        ram_req_o.en   = 1'b1;
        ram_req_o.we   = 1'b1;
        ram_req_o.addr = cnt_r;
        ram_req_o.mask = '1;
        if (cnt_r == `DIR_ROW_W'(`DIR_ROWS - 1)) begin
          cnt_n   = '0;
          state_n = e_st_ready;
        end else begin
          cnt_n = cnt_r + 1'b1;
        end
      end

      e_st_ready: begin
        busy_o = 1'b0;
        if (cmd_v_i) begin
          // old sharers are stale once any command lands
          collect_o.clear = 1'b1;
          lce_n = cmd_i.lce;
          way_n = cmd_i.way;
          tag_n = cmd_tag;
          cnt_n = '0;

          ram_req_o.en   = 1'b1;
          ram_req_o.addr = entry_row;

          case (cmd_i.op)
            e_op_rdw: begin
              // first row of the set is the set index itself
              ram_req_o.addr = `DIR_ROW_W'(set_idx);
              row_n   = `DIR_ROW_W'(set_idx) + `DIR_ROW_W'(`DIR_SETS);
              state_n = e_st_read_full;
            end
            e_op_rde: begin
              state_n = e_st_read_entry;
            end
            e_op_wde: begin
              ram_req_o.we = 1'b1;
              ram_req_o.mask.tag_set[cmd_slot][cmd_i.way]       = '1;
              ram_req_o.data.tag_set[cmd_slot][cmd_i.way].tag   = cmd_tag;
              ram_req_o.data.tag_set[cmd_slot][cmd_i.way].state = cmd_i.state;
            end
            e_op_wds: begin
              // tag bits stay out of the mask
              ram_req_o.we = 1'b1;
              ram_req_o.mask.tag_set[cmd_slot][cmd_i.way].state = coh_state_e'('1);
              ram_req_o.data.tag_set[cmd_slot][cmd_i.way].state = cmd_i.state;
            end
            e_op_clr: begin
              // whole row, both caches sharing it go invalid
              ram_req_o.we   = 1'b1;
              ram_req_o.mask = '1;
            end
            default: begin
              ram_req_o.en = 1'b0;
            end
          endcase
        end
      end

      e_st_read_full: begin
        // row data from the previous request is on the ram output now
        for (int s = 0; s < `DIR_TAG_SETS_PER_ROW; s++) begin
          // odd cache count, the last row has slot 0 only
          slot_v_o[s] = (int'(cnt_r) * `DIR_TAG_SETS_PER_ROW + s) < `DIR_NUM_LCE;
        end
        collect_o.capture_full = 1'b1;
        collect_o.row_num      = `DIR_LCE_W'(cnt_r);
        if (last_row) begin
          collect_o.done = 1'b1;
          cnt_n   = '0;
          state_n = e_st_ready;
        end else begin
          // issue the next row of the same set
          ram_req_o.en   = 1'b1;
          ram_req_o.addr = row_r;
          row_n = row_r + `DIR_ROW_W'(`DIR_SETS);
          cnt_n = cnt_r + 1'b1;
        end
      end

      e_st_read_entry: begin
        slot_v_o[lce_r[0]]      = 1'b1;
        collect_o.capture_entry = 1'b1;
        collect_o.slot_sel      = lce_r[0];
        collect_o.done          = 1'b1;
        state_n = e_st_ready;
      end

      default: begin
        state_n = e_st_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_st_reset;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      cnt_r   <= cnt_n;
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    lce_r <= lce_n;
    way_r <= way_n;
    tag_r <= tag_n;
    row_r <= row_n;
  end

endmodule

//--- design/dir_sharers_collect.sv
`timescale 1ns/10ps
`include "dir_cfg.svh"

module dir_sharers_collect (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  dir_pkg::tag_res_s [`DIR_TAG_SETS_PER_ROW-1:0] res_i,
  input  dir_pkg::collect_s                            collect_i,
  output dir_pkg::dir_sharers_s                        sharers_o,
  output logic                                         addr_v_o,
  output logic [`DIR_PADDR_W-1:0]                      addr_o
);
  import dir_pkg::*;

  dir_sharers_s sharers_r, sharers_n;
  // result of the slot addressed by an entry read
  tag_res_s     entry_res;

  assign entry_res = res_i[collect_i.slot_sel];

  // stored block address, same cycle as the ram data
  assign addr_v_o = collect_i.capture_entry;
  assign addr_o   = {entry_res.sel_tag, {`DIR_TAG_OFF{1'b0}}};

  always_comb begin : p_next
    int pos;
    pos       = 0;
    sharers_n = sharers_r;
    if (collect_i.clear) begin
      sharers_n = '0;
    end
    if (collect_i.capture_full) begin
      for (int s = 0; s < `DIR_TAG_SETS_PER_ROW; s++) begin
        // cache number is row number times slots per row plus slot
        pos = int'(collect_i.row_num) * `DIR_TAG_SETS_PER_ROW + s;
        // past the cache count on a half used row
        if (pos < `DIR_NUM_LCE) begin
          sharers_n.hits[pos]   = res_i[s].hit;
          sharers_n.ways[pos]   = res_i[s].way;
          sharers_n.states[pos] = res_i[s].state;
        end
      end
    end
    if (collect_i.capture_entry) begin
      // entry read reports in position 0
      sharers_n.hits[0]   = entry_res.sel_hit;
      sharers_n.ways[0]   = entry_res.way;
      sharers_n.states[0] = entry_res.sel_state;
    end
    if (collect_i.done) begin
      sharers_n.v = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sharers_r.v <= 1'b0;
    end else begin
      sharers_r <= sharers_n;
    end
  end

  assign sharers_o = sharers_r;

endmodule

//--- design/dir_segment.sv
`timescale 1ns/10ps
`include "dir_cfg.svh"

module dir_segment (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    cmd_v_i,
  input  dir_pkg::dir_cmd_s       cmd_i,
  output logic                    busy_o,
  output dir_pkg::dir_sharers_s   sharers_o,
  output logic                    addr_v_o,
  output logic [`DIR_PADDR_W-1:0] addr_o
);
  import dir_pkg::*;

  // controller to row memory
  ram_req_s ram_req;
  // row read out, one cycle after the request
  dir_row_s ram_row;

  // controller to tag checks
  logic [`DIR_TAG_SETS_PER_ROW-1:0] slot_v;
  logic [`DIR_TAG_W-1:0]            req_tag;
  logic [`DIR_WAY_W-1:0]            sel_way;

  // tag checks to collector
  tag_res_s [`DIR_TAG_SETS_PER_ROW-1:0] tag_res;
  collect_s                             collect;

  dir_ctrl u_ctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .cmd_v_i   (cmd_v_i),
    .cmd_i     (cmd_i),
    .busy_o    (busy_o),
    .ram_req_o (ram_req),
    .slot_v_o  (slot_v),
    .tag_o     (req_tag),
    .sel_way_o (sel_way),
    .collect_o (collect)
  );

  dir_ram u_ram (
    .clk_i (clk_i),
    .req_i (ram_req),
    .row_o (ram_row)
  );

  // one checker per tag set of the row
  for (genvar g = 0; g < `DIR_TAG_SETS_PER_ROW; g++) begin : g_tag_check
    dir_tag_check u_tag_check (
      .entries_i (ram_row.tag_set[g]),
      .slot_v_i  (slot_v[g]),
      .tag_i     (req_tag),
      .sel_way_i (sel_way),
      .res_o     (tag_res[g])
    );
  end

  dir_sharers_collect u_collect (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .res_i     (tag_res),
    .collect_i (collect),
    .sharers_o (sharers_o),
    .addr_v_o  (addr_v_o),
    .addr_o    (addr_o)
  );

endmodule

//--- sim/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
  output logic clk_o,
  output logic reset_o
);
  // 4 ns period
  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // held over RESET_CYCLES rising edges, dropped on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

//--- sim/tb_dir_segment.sv
`timescale 1ns/10ps
`include "dir_cfg.svh"

module tb_dir_segment;
  import dir_pkg::*;

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 64;

  logic                    clk;
  logic                    reset;
  logic                    cmd_v;
  dir_cmd_s                cmd;
  logic                    busy;
  dir_sharers_s            sharers;
  logic                    addr_v;
  logic [`DIR_PADDR_W-1:0] addr;

  // shadow directory indexed by cache, set and way
  logic [`DIR_TAG_W-1:0] sh_tag   [`DIR_NUM_LCE][`DIR_SETS][`DIR_ASSOC];
  coh_state_e            sh_state [`DIR_NUM_LCE][`DIR_SETS][`DIR_ASSOC];

  dir_sharers_s exp_sharers;
  event         check_ev;
  int           err_cnt;
  int           test_err;
  int           test_cnt;
  bit           timed_out;

  tb_clkgen u_clkgen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  dir_segment UUT (
    .clk_i     (clk),
    .reset_i   (reset),
    .cmd_v_i   (cmd_v),
    .cmd_i     (cmd),
    .busy_o    (busy),
    .sharers_o (sharers),
    .addr_v_o  (addr_v),
    .addr_o    (addr)
  );

  // set index sits right above the block offset
  function automatic int set_of(input dir_cmd_s c);
    return int'(c.addr[`DIR_TAG_OFF-1:`DIR_BLOCK_OFF_W]);
  endfunction

  function automatic dir_cmd_s make_cmd(input dir_op_e op, input int lce, input int way,
                                        input int set, input logic [`DIR_TAG_W-1:0] tag,
                                        input coh_state_e st);
    dir_cmd_s c;
    c.op    = op;
    c.lce   = `DIR_LCE_W'(lce);
    c.way   = `DIR_WAY_W'(way);
    // byte offset is random and must not matter
    c.addr  = {tag, `DIR_SET_W'(set), `DIR_BLOCK_OFF_W'($urandom)};
    c.state = st;
    return c;
  endfunction

  // expected sharers of a full or entry read
  function automatic dir_sharers_s model_read(input dir_cmd_s c);
    dir_sharers_s          r;
    logic [`DIR_TAG_W-1:0] tag;
    int                    set;
    int                    lo;
    int                    hi;
    int                    pos;
    r   = '0;
    r.v = 1'b1;
    tag = c.addr[`DIR_PADDR_W-1:`DIR_TAG_OFF];
    set = set_of(c);
    lo  = (c.op == e_op_rde) ? int'(c.lce) : 0;
    hi  = (c.op == e_op_rde) ? int'(c.lce) : `DIR_NUM_LCE - 1;
    for (int l = lo; l <= hi; l++) begin
      // entry read lands in position 0
      pos = (c.op == e_op_rde) ? 0 : l;
      // walk down so the lowest valid matching way is reported
      for (int w = `DIR_ASSOC - 1; w >= 0; w--) begin
        if (sh_state[l][set][w] != e_coh_i && sh_tag[l][set][w] == tag) begin
          r.hits[pos]   = 1'b1;
          r.ways[pos]   = `DIR_WAY_W'(w);
          r.states[pos] = sh_state[l][set][w];
        end
      end
    end
    if (c.op == e_op_rde) begin
      // hit and state of the addressed way itself
      r.hits[0]   = sh_state[c.lce][set][c.way] != e_coh_i && sh_tag[c.lce][set][c.way] == tag;
      r.states[0] = sh_state[c.lce][set][c.way];
    end
    return r;
  endfunction

  task automatic model_write(input dir_cmd_s c);
    int set;
    int base;
    set  = set_of(c);
    // caches 2k and 2k+1 share a row
    base = (int'(c.lce) / 2) * 2;
    case (c.op)
      e_op_wde: begin
        sh_tag[c.lce][set][c.way]   = c.addr[`DIR_PADDR_W-1:`DIR_TAG_OFF];
        sh_state[c.lce][set][c.way] = c.state;
      end
      e_op_wds: sh_state[c.lce][set][c.way] = c.state;
      e_op_clr: begin
        for (int l = base; l < base + 2 && l < `DIR_NUM_LCE; l++) begin
          for (int w = 0; w < `DIR_ASSOC; w++) begin
            sh_tag[l][set][w]   = '0;
            sh_state[l][set][w] = e_coh_i;
          end
        end
      end
      default: ;
    endcase
  endtask

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      test_err++;
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // compares the sharers once the read result is valid
  always @(check_ev) begin
    check_val("sharers v", 32'(sharers.v), 32'(exp_sharers.v));
    check_val("sharers hits", 32'(sharers.hits), 32'(exp_sharers.hits));
    check_val("sharers ways", 32'(sharers.ways), 32'(exp_sharers.ways));
    check_val("sharers states", 32'(sharers.states), 32'(exp_sharers.states));
  end

  task automatic end_run();
    $display("tests %0d, mismatches %0d", test_cnt, err_cnt);
    if (err_cnt == 0 && !timed_out) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  function automatic bit cond_met(input int which);
    case (which)
      0: return !busy;
      1: return sharers.v;
      default: return !reset;
    endcase
  endfunction

  // code 0 waits for idle, 1 for sharers valid and 2 for reset release
  task automatic wait_until(input int which, input string what);
    int n;
    n = 0;
    while (!cond_met(which) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!cond_met(which)) begin
      $display("timeout at %0t ns: %s did not happen within %0d cycles", $time, what,
               WAIT_LIMIT);
      timed_out = 1'b1;
      end_run();
    end
  endtask

  // holds cmd_v for one cycle once idle and returns on the falling edge after acceptance
  task automatic issue(input dir_cmd_s c);
    wait_until(0, "busy_o low");
    cmd   = c;
    cmd_v = 1'b1;
    @(negedge clk);
    cmd_v = 1'b0;
    // any accepted command drops the old sharers result
    check_val("sharers v after accept", 32'(sharers.v), 32'(0));
  endtask

  task automatic do_write(input dir_cmd_s c);
    issue(c);
    model_write(c);
    check_val("busy_o after write", 32'(busy), 32'(0));
  endtask

  task automatic read_result(input dir_cmd_s c);
    wait_until(0, "busy_o low");
    wait_until(1, "sharers_o.v high");
    check_val("addr_v_o after read", 32'(addr_v), 32'(0));
    exp_sharers = model_read(c);
    -> check_ev;
    @(negedge clk);
  endtask

  task automatic do_read(input dir_cmd_s c);
    logic [`DIR_PADDR_W-1:0] exp_addr;
    issue(c);
    exp_addr = {sh_tag[c.lce][set_of(c)][c.way], {`DIR_TAG_OFF{1'b0}}};
    // entry address pulses in the cycle after acceptance
    check_val("addr_v_o", 32'(addr_v), 32'(c.op == e_op_rde));
    if (c.op == e_op_rde) begin
      check_val("addr_o", 32'(addr), 32'(exp_addr));
    end
    read_result(c);
  endtask

  task automatic close_test(input string name);
    test_cnt++;
    $display("%-16s %0d mismatches", name, test_err);
    test_err = 0;
  endtask

  initial begin
    logic [`DIR_TAG_W-1:0] pool [2];
    dir_cmd_s              rd;
    int                    s;
    void'($urandom(34));
    cmd_v     = 1'b0;
    cmd       = '0;
    err_cnt   = 0;
    test_err  = 0;
    test_cnt  = 0;
    timed_out = 1'b0;
    for (int l = 0; l < `DIR_NUM_LCE; l++) begin
      for (int i = 0; i < `DIR_SETS; i++) begin
        for (int w = 0; w < `DIR_ASSOC; w++) begin
          sh_tag[l][i][w]   = '0;
          sh_state[l][i][w] = e_coh_i;
        end
      end
    end
    // two distinct tags so reads see both hits and misses
    pool[0] = `DIR_TAG_W'($urandom);
    pool[1] = ~pool[0];

    @(negedge clk);
    wait_until(2, "reset release");
    check_val("sharers v after reset", 32'(sharers.v), 32'(0));
    check_val("busy_o after reset", 32'(busy), 32'(1));
    do_read(make_cmd(e_op_rdw, 0, 0, $urandom_range(3, 0), pool[0], e_coh_i));
    close_test("reset_clear");

    // every fourth write goes to cache 2 in the half used row
    for (int i = 0; i < 16; i++) begin
      do_write(make_cmd(e_op_wde, (i % 4 == 3) ? 2 : $urandom_range(2, 0),
                        $urandom_range(1, 0), $urandom_range(3, 0),
                        pool[$urandom_range(1, 0)], coh_state_e'($urandom_range(5, 1))));
    end
    for (int i = 0; i < `DIR_SETS; i++) begin
      for (int t = 0; t < 2; t++) begin
        do_read(make_cmd(e_op_rdw, 0, 0, i, pool[t], e_coh_i));
      end
    end
    close_test("write_full_read");

    // state write carries a different tag that must not land
    do_write(make_cmd(e_op_wde, 2, 1, 1, pool[0], e_coh_m));
    do_write(make_cmd(e_op_wds, 2, 1, 1, pool[1], e_coh_s));
    do_read(make_cmd(e_op_rdw, 0, 0, 1, pool[0], e_coh_i));
    do_read(make_cmd(e_op_rde, 2, 1, 1, pool[0], e_coh_i));
    close_test("write_state");

    for (int l = 0; l < `DIR_NUM_LCE; l++) begin
      for (int w = 0; w < `DIR_ASSOC; w++) begin
        do_read(make_cmd(e_op_rde, l, w, $urandom_range(3, 0), pool[$urandom_range(1, 0)],
                         e_coh_i));
      end
    end
    close_test("entry_read");

    // fill set s and its neighbour and then clear the row of caches 0 and 1
    s = $urandom_range(3, 0);
    for (int l = 0; l < `DIR_NUM_LCE; l++) begin
      do_write(make_cmd(e_op_wde, l, 0, s, pool[0], e_coh_e));
      do_write(make_cmd(e_op_wde, l, 0, (s + 1) % `DIR_SETS, pool[0], e_coh_e));
    end
    do_write(make_cmd(e_op_clr, 1, 0, s, pool[0], e_coh_i));
    do_read(make_cmd(e_op_rdw, 0, 0, s, pool[0], e_coh_i));
    do_read(make_cmd(e_op_rdw, 0, 0, (s + 1) % `DIR_SETS, pool[0], e_coh_i));
    close_test("clear_row");

    // write driven while a full read holds busy_o high
    do_write(make_cmd(e_op_wde, 0, 0, s, pool[0], e_coh_s));
    rd = make_cmd(e_op_rdw, 0, 0, s, pool[1], e_coh_i);
    issue(rd);
    check_val("busy_o during full read", 32'(busy), 32'(1));
    cmd   = make_cmd(e_op_wde, 0, 0, s, pool[1], e_coh_m);
    cmd_v = 1'b1;
    @(negedge clk);
    cmd_v = 1'b0;
    read_result(rd);
    do_read(make_cmd(e_op_rde, 0, 0, s, pool[1], e_coh_i));
    do_read(make_cmd(e_op_rde, 0, 0, s, pool[0], e_coh_i));
    close_test("busy_ignore");

    end_run();
  end

endmodule

//--- sim.f
+incdir+include
design/dir_pkg.sv
design/dir_ram.sv
design/dir_tag_check.sv
design/dir_ctrl.sv
design/dir_sharers_collect.sv
design/dir_segment.sv
sim/tb_clkgen.sv
sim/tb_dir_segment.sv

//--- run.sh
#!/bin/sh
# build and run the directory segment testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -Mdir obj_dir \
  --top-module tb_dir_segment -f sim.f > build.log 2>&1

./obj_dir/Vtb_dir_segment > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "simulation ended without a result line, see sim.log"
  exit 1
fi
